/* build.f */
verilog/uart_cmd_pkg.sv
verilog/uart_baud_cfg.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/uart_cmd_master.sv
verilog/uart_cmd_top.sv
verification/uart_cmd_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
  --top-module uart_cmd_tb -Mdir "$OBJ" -f build.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$OBJ/Vuart_cmd_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation did not pass, see $LOG"
exit 1

/* verification/uart_cmd_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_tb;

  localparam int CLK_PERIOD    = 20;
  localparam int CLK_HZ        = 50_000_000;
  localparam int BAUD          = 2_500_000;
  localparam int DIV_RESET     = CLK_HZ / BAUD;
  localparam int RESP_TMO_BITS = 40;
  localparam int N_RW          = 8;
  localparam int MAX_WAIT      = 80 * DIV_RESET;
  // worst case bit periods over all tests at the largest divisor used
  localparam int WORST_BITS    = (N_RW + 5) * 2 * uart_cmd_pkg::FRAME_BITS
                                 + (N_RW + 1) * (2 * uart_cmd_pkg::FRAME_BITS + 10)
                                 + uart_cmd_pkg::FRAME_BITS + RESP_TMO_BITS;
  localparam int WATCHDOG_NS   = 2 * WORST_BITS * DIV_RESET * CLK_PERIOD + 16 * CLK_PERIOD;

  logic                     clk = 1'b0;
  logic                     rst_n;
  uart_cmd_pkg::uart_cmd_t  cmd;
  logic                     cmd_vld;
  wire                      cmd_rdy;
  logic                     cfg_wr;
  uart_cmd_pkg::divisor_t   cfg_divisor;
  wire                      tx;
  logic                     rx;
  wire                      resp_vld;
  uart_cmd_pkg::uart_resp_t resp;

  // remote device and test model state
  uart_cmd_pkg::byte_t dev_mem [128];
  uart_cmd_pkg::byte_t exp_mem [128];
  uart_cmd_pkg::byte_t frames [$];
  uart_cmd_pkg::byte_t reply_byte;
  int                  reply_req = 0;
  int                  reply_gap;
  logic                silent;
  logic                corrupt;
  int                  cur_div;
  longint              stop_time;
  int                  seed = 6267;
  int                  err_cnt = 0;
  int                  pass_cnt = 0;
  int                  fail_cnt = 0;

  uart_cmd_top #(
    .CLK_HZ            (CLK_HZ),
    .BAUD              (BAUD),
    .RESP_TIMEOUT_BITS (RESP_TMO_BITS)
  ) i_uart_cmd_top (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd         (cmd),
    .cmd_vld     (cmd_vld),
    .cmd_rdy     (cmd_rdy),
    .cfg_wr      (cfg_wr),
    .cfg_divisor (cfg_divisor),
    .tx          (tx),
    .rx          (rx),
    .resp_vld    (resp_vld),
    .resp        (resp)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic flag_error(input string msg);
    $display("CHECK FAILED at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic note_failure(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    err_cnt++;
  endtask

  task automatic end_test(input string name, input int err_before);
    if (err_cnt == err_before) begin
      pass_cnt++;
      $display("test %s: passed", name);
    end else begin
      fail_cnt++;
      $display("test %s: failed with %0d errors", name, err_cnt - err_before);
    end
  endtask

  function automatic uart_cmd_pkg::byte_t fill_byte(input int a);
    return 8'(a * 7) ^ 8'h3c;
  endfunction

  // 1 when the byte has an even count of ones
  function automatic logic odd_parity(input uart_cmd_pkg::byte_t b);
    return ($countones(b) % 2 == 0);
  endfunction

  function automatic uart_cmd_pkg::uart_cmd_t make_cmd(input logic rw,
                                                       input uart_cmd_pkg::addr_t a,
                                                       input uart_cmd_pkg::byte_t d);
    uart_cmd_pkg::uart_cmd_t c;
    c.rw   = rw;
    c.addr = a;
    c.data = d;
    return c;
  endfunction

  rdy_with_resp: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |-> cmd_rdy)
    else flag_error("cmd_rdy low while resp_vld is high");
  resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n) resp_vld |=> !resp_vld)
    else flag_error("resp_vld longer than one cycle");
  rdy_drops: assert property (@(posedge clk) disable iff (!rst_n)
    (cmd_vld && cmd_rdy) |=> !cmd_rdy)
    else flag_error("cmd_rdy still high after acceptance");

  task automatic issue_cmd(input uart_cmd_pkg::uart_cmd_t c);
    int guard;
    guard = 0;
    @(posedge clk);
    cmd     <= c;
    cmd_vld <= 1'b1;
    do begin
      @(posedge clk);
      guard++;
    end while (!cmd_rdy && guard < MAX_WAIT);
    cmd_vld <= 1'b0;
    if (!cmd_rdy) note_failure("command was never accepted");
  endtask

  task automatic wait_write_done();
    int guard;
    guard = 0;
    do begin
      @(posedge clk);
      guard++;
      assert (!resp_vld) else flag_error("resp_vld after a write");
    end while (!cmd_rdy && guard < MAX_WAIT);
    if (!cmd_rdy) note_failure("cmd_rdy did not come back after a write");
  endtask

  task automatic wait_resp(output uart_cmd_pkg::uart_resp_t r, output longint t);
    int guard;
    guard = 0;
    do begin
      @(posedge clk);
      guard++;
    end while (!resp_vld && guard < MAX_WAIT);
    r = resp;
    t = $time;
    if (!resp_vld) note_failure("read ended without resp_vld");
  endtask

  task automatic check_write_frames(input int idx, input uart_cmd_pkg::uart_cmd_t c,
                                    input int total);
    assert (frames.size() == total)
      else flag_error($sformatf("%0d tx frames, expected %0d", frames.size(), total));
    assert (frames[idx] == {1'b0, c.addr})
      else flag_error($sformatf("head frame %h, expected %h", frames[idx], {1'b0, c.addr}));
    assert (frames[idx + 1] == c.data)
      else flag_error($sformatf("data frame %h, expected %h", frames[idx + 1], c.data));
  endtask

  task automatic do_write(input uart_cmd_pkg::uart_cmd_t c);
    int n0;
    n0 = frames.size();
    issue_cmd(c);
    wait_write_done();
    check_write_frames(n0, c, n0 + 2);
    exp_mem[c.addr] = c.data;
  endtask

  task automatic do_read(input uart_cmd_pkg::addr_t a, output uart_cmd_pkg::uart_resp_t r,
                         output longint t);
    int n0;
    n0 = frames.size();
    reply_gap = 2 + int'($unsigned($random(seed)) % 32'd9);
    issue_cmd(make_cmd(1'b1, a, 8'h00));
    wait_resp(r, t);
    assert (frames.size() == n0 + 1 && frames[n0] == {1'b1, a})
      else flag_error($sformatf("read head frame %h, expected %h", frames[n0], {1'b1, a}));
  endtask

  task automatic set_divisor(input uart_cmd_pkg::divisor_t v);
    @(posedge clk);
    cfg_wr      <= 1'b1;
    cfg_divisor <= v;
    @(posedge clk);
    cfg_wr <= 1'b0;
    cur_div = (v < uart_cmd_pkg::DIVISOR_MIN) ? int'(uart_cmd_pkg::DIVISOR_MIN) : int'(v);
  endtask

  // odd address so the start bit ends on a rising edge
  task automatic measure_bit_period(input uart_cmd_pkg::divisor_t v);
    uart_cmd_pkg::uart_cmd_t c;
    int                      period;
    int                      n0;
    set_divisor(v);
    c  = make_cmd(1'b0, 7'($random(seed)) | 7'h01, 8'($random(seed)));
    n0 = frames.size();
    issue_cmd(c);
    // first sample shows the cycle right after acceptance
    @(posedge clk);
    assert (!tx) else flag_error("start bit not one cycle after acceptance");
    period = 0;
    while (!tx && period < MAX_WAIT) begin
      period++;
      @(posedge clk);
    end
    assert (period == cur_div)
      else flag_error($sformatf("bit period %0d, expected %0d", period, cur_div));
    wait_write_done();
    check_write_frames(n0, c, n0 + 2);
  endtask

  // remote register device decoding tx at the current divisor
  initial begin : remote_device
    uart_cmd_pkg::byte_t data;
    uart_cmd_pkg::addr_t wr_addr;
    logic                start_bit;
    logic                par_bit;
    logic                stop_bit;
    logic                want_data;
    int                  div;
    int                  i;
    want_data = 1'b0;
    wr_addr   = '0;
    forever begin
      @(negedge tx);
      div = cur_div;
      repeat (div / 2) @(posedge clk);
      start_bit = tx;
      for (i = 0; i < 8; i++) begin
        repeat (div) @(posedge clk);
        data[i] = tx;
      end
      repeat (div) @(posedge clk);
      par_bit = tx;
      repeat (div) @(posedge clk);
      stop_bit  = tx;
      stop_time = $time;
      assert (start_bit == 1'b0 && stop_bit == 1'b1 && $countones({par_bit, data}) % 2 == 1)
        else flag_error($sformatf("bad tx frame, start %b data %h parity %b stop %b",
                                  start_bit, data, par_bit, stop_bit));
      frames.push_back(data);
      if (want_data) begin
        dev_mem[wr_addr] = data;
        want_data        = 1'b0;
      end else if (data[7]) begin
        reply_byte = dev_mem[data[6:0]];
        reply_req++;
      end else begin
        wr_addr   = data[6:0];
        want_data = 1'b1;
      end
    end
  end

  initial begin : reply_driver
    int          served;
    int          div;
    int          i;
    logic [10:0] bits;
    served = 0;
    rx     = 1'b1;
    forever begin
      wait (reply_req != served);
      served = reply_req;
      div    = cur_div;
      if (!silent) begin
        bits = {1'b1, odd_parity(reply_byte) ^ corrupt, reply_byte, 1'b0};
        repeat (reply_gap * div) @(posedge clk);
        for (i = 0; i < uart_cmd_pkg::FRAME_BITS; i++) begin
          rx <= bits[i];
          repeat (div) @(posedge clk);
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
    $display("Something failed");
    $finish;
  end

  initial begin : main
    uart_cmd_pkg::uart_cmd_t  c1;
    uart_cmd_pkg::uart_cmd_t  c2;
    uart_cmd_pkg::uart_resp_t r;
    uart_cmd_pkg::addr_t      addrs [N_RW];
    longint                   t_resp;
    longint                   t_end;
    int                       n0;
    int                       err0;
    int                       i;
    rst_n       = 1'b0;
    cmd         = '0;
    cmd_vld     = 1'b0;
    cfg_wr      = 1'b0;
    cfg_divisor = '0;
    silent      = 1'b0;
    corrupt     = 1'b0;
    reply_gap   = 2;
    cur_div     = DIV_RESET;
    for (i = 0; i < 128; i++) begin
      dev_mem[i] = fill_byte(i);
      exp_mem[i] = fill_byte(i);
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);

    err0 = err_cnt;
    assert (cmd_rdy && tx && !resp_vld) else flag_error("outputs wrong after reset");
    do_write(make_cmd(1'b0, 7'($random(seed)), 8'($random(seed))));
    end_test("write framing", err0);

    err0 = err_cnt;
    for (i = 0; i < N_RW; i++) begin
      addrs[i] = 7'($random(seed));
      do_write(make_cmd(1'b0, addrs[i], 8'($random(seed))));
    end
    for (i = 0; i < N_RW; i++) begin
      do_read(addrs[i], r, t_resp);
      assert (r.data == exp_mem[addrs[i]] && !r.parity_err && !r.timeout)
        else flag_error($sformatf("read %h gave %h perr %b tmo %b, expected %h",
                                  addrs[i], r.data, r.parity_err, r.timeout, exp_mem[addrs[i]]));
    end
    end_test("read-back", err0);

    err0    = err_cnt;
    corrupt = 1'b1;
    do_read(addrs[0], r, t_resp);
    corrupt = 1'b0;
    assert (r.parity_err && !r.timeout)
      else flag_error($sformatf("perr %b tmo %b, expected perr 1", r.parity_err, r.timeout));
    end_test("parity error", err0);

    err0   = err_cnt;
    silent = 1'b1;
    do_read(addrs[1], r, t_resp);
    assert (cmd_rdy) else flag_error("cmd_rdy low after the timeout");
    silent = 1'b0;
    t_end  = stop_time + longint'((cur_div - cur_div / 2) * CLK_PERIOD);
    assert (r.timeout && !r.parity_err)
      else flag_error($sformatf("tmo %b perr %b, expected tmo 1", r.timeout, r.parity_err));
    assert (t_resp - t_end >= longint'(RESP_TMO_BITS * cur_div * CLK_PERIOD))
      else flag_error($sformatf("timeout after %0d ns only", t_resp - t_end));
    end_test("reply timeout", err0);

    err0 = err_cnt;
    measure_bit_period(16'd12);
    measure_bit_period(16'd2);
    end_test("divisor change", err0);

    // pulses while busy must be dropped
    err0 = err_cnt;
    c1   = make_cmd(1'b0, 7'($random(seed)), 8'($random(seed)));
    c2   = make_cmd(1'b0, 7'($random(seed)), 8'($random(seed)));
    n0   = frames.size();
    issue_cmd(c1);
    repeat (3) begin
      @(posedge clk);
      cmd     <= make_cmd(1'b0, 7'($random(seed)), 8'($random(seed)));
      cmd_vld <= 1'b1;
      @(posedge clk);
      assert (!cmd_rdy) else flag_error("cmd_rdy high during a busy pulse");
      cmd_vld <= 1'b0;
    end
    wait_write_done();
    issue_cmd(c2);
    wait_write_done();
    check_write_frames(n0, c1, n0 + 4);
    check_write_frames(n0 + 2, c2, n0 + 4);
    end_test("back-pressure", err0);

    $display("tests passed %0d, tests failed %0d, failed checks %0d",
             pass_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/uart_cmd_top.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_top #(
  parameter int CLK_HZ            = 50_000_000,
  parameter int BAUD              = 115_200,
  parameter int RESP_TIMEOUT_BITS = 40
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire uart_cmd_pkg::uart_cmd_t  cmd,
  input  wire                           cmd_vld,
  output wire                           cmd_rdy,
  input  wire                           cfg_wr,
  input  wire uart_cmd_pkg::divisor_t   cfg_divisor,
  output wire                           tx,
  input  wire                           rx,
  output wire                           resp_vld,
  output uart_cmd_pkg::uart_resp_t      resp
);

  uart_cmd_pkg::divisor_t divisor;
  uart_cmd_pkg::byte_t    tx_byte;
  uart_cmd_pkg::rx_byte_t rx_out;
  wire                    tx_start;
  wire                    tx_done;
  wire                    rx_en;
  wire                    rx_vld;
  wire                    rx_busy;

  uart_baud_cfg #(
    .CLK_HZ (CLK_HZ),
    .BAUD   (BAUD)
  ) i_uart_baud_cfg (
    .clk         (clk),
    .rst_n       (rst_n),
    .cfg_wr      (cfg_wr),
    .cfg_divisor (cfg_divisor),
    .divisor     (divisor)
  );

  uart_cmd_master #(
    .RESP_TIMEOUT_BITS (RESP_TIMEOUT_BITS)
  ) i_uart_cmd_master (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .divisor  (divisor),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .rx_en    (rx_en),
    .rx_vld   (rx_vld),
    .rx_out   (rx_out),
    .rx_busy  (rx_busy),
    .resp_vld (resp_vld),
    .resp     (resp)
  );

  uart_tx_frame i_uart_tx_frame (
    .clk      (clk),
    .rst_n    (rst_n),
    .divisor  (divisor),
    .tx_start (tx_start),
    .tx_byte  (tx_byte),
    .tx       (tx),
    .tx_done  (tx_done)
  );

  uart_rx_frame i_uart_rx_frame (
    .clk     (clk),
    .rst_n   (rst_n),
    .divisor (divisor),
    .rx      (rx),
    .rx_en   (rx_en),
    .rx_vld  (rx_vld),
    .rx_out  (rx_out),
    .rx_busy (rx_busy)
  );

endmodule

`default_nettype wire

/* verilog/uart_cmd_master.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_cmd_master #(
  parameter int RESP_TIMEOUT_BITS = 40
) (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire uart_cmd_pkg::uart_cmd_t  cmd,
  input  wire                           cmd_vld,
  output logic                          cmd_rdy,
  input  wire uart_cmd_pkg::divisor_t   divisor,
  output logic                          tx_start,
  output uart_cmd_pkg::byte_t           tx_byte,
  input  wire                           tx_done,
  output logic                          rx_en,
  input  wire                           rx_vld,
  input  wire uart_cmd_pkg::rx_byte_t   rx_out,
  input  wire                           rx_busy,
  output logic                          resp_vld,
  output uart_cmd_pkg::uart_resp_t      resp
);

  localparam int TMO_W = $clog2(RESP_TIMEOUT_BITS + 1);
  localparam logic [TMO_W-1:0] TMO_LAST = TMO_W'(RESP_TIMEOUT_BITS - 1);

  uart_cmd_pkg::master_state_t state;
  uart_cmd_pkg::master_state_t state_nxt;
  uart_cmd_pkg::uart_cmd_t     cmd_q;
  uart_cmd_pkg::divisor_t      tmo_cnt;
  logic [TMO_W-1:0]            tmo_bits;
  logic                        tmo_tick;
  logic                        tmo_expire;
  logic                        cmd_accept;
  logic                        data_start;

  // finish also takes the next command, so rdy rises with resp_vld
  assign cmd_rdy    = (state == uart_cmd_pkg::idle) || (state == uart_cmd_pkg::finish);
  assign cmd_accept = cmd_vld && cmd_rdy;
  assign data_start = (state == uart_cmd_pkg::send_head) && tx_done && !cmd_q.rw;
  assign tx_start   = cmd_accept || data_start;

  // head byte straight from the host port, so tx starts next cycle
  assign tx_byte = (state == uart_cmd_pkg::send_head) ? cmd_q.data : {cmd.rw, cmd.addr};

  assign rx_en    = (state == uart_cmd_pkg::wait_reply);
  assign resp_vld = (state == uart_cmd_pkg::finish);

  // reply timer, held while a reply frame is coming in
  assign tmo_tick   = rx_en && !rx_busy && (tmo_cnt == divisor - 1'b1);
  assign tmo_expire = tmo_tick && (tmo_bits == TMO_LAST);

  always_comb begin
    state_nxt = state;
    case (state)
      uart_cmd_pkg::idle,
      uart_cmd_pkg::finish: begin
        state_nxt = cmd_accept ? uart_cmd_pkg::send_head : uart_cmd_pkg::idle;
      end
      uart_cmd_pkg::send_head: begin
        if (tx_done) begin
          state_nxt = cmd_q.rw ? uart_cmd_pkg::wait_reply : uart_cmd_pkg::send_data;
        end
      end
      uart_cmd_pkg::send_data: begin
        if (tx_done) begin
          state_nxt = uart_cmd_pkg::idle;
        end
      end
      uart_cmd_pkg::wait_reply: begin
        if (rx_vld || tmo_expire) begin
          state_nxt = uart_cmd_pkg::finish;
        end
      end
      default: begin
        state_nxt = uart_cmd_pkg::idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= uart_cmd_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      tmo_cnt  <= '0;
      tmo_bits <= '0;
    end else if (!rx_en) begin
      tmo_cnt  <= '0;
      tmo_bits <= '0;
    end else if (!rx_busy) begin
      if (tmo_tick) begin
        tmo_cnt  <= '0;
        tmo_bits <= tmo_bits + 1'b1;
      end else begin
        tmo_cnt <= tmo_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      cmd_q <= cmd;
    end
    if (rx_en && rx_vld) begin
      resp.data       <= rx_out.data;
      resp.parity_err <= rx_out.parity_err || rx_out.stop_err;
      resp.timeout    <= 1'b0;
    end else if (tmo_expire) begin
      resp.data       <= '0;
      resp.parity_err <= 1'b0;
      resp.timeout    <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_rx_frame.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_rx_frame (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire uart_cmd_pkg::divisor_t  divisor,
  input  wire                          rx,
  input  wire                          rx_en,
  output logic                         rx_vld,
  output uart_cmd_pkg::rx_byte_t       rx_out,
  output logic                         rx_busy
);

  localparam logic [3:0] LAST_BIT   = 4'(uart_cmd_pkg::FRAME_BITS - 1);
  localparam logic [3:0] PARITY_BIT = 4'(uart_cmd_pkg::FRAME_BITS - 2);

  logic                   rx_s1;
  logic                   rx_s2;
  logic                   rx_s3;
  logic                   fall;
  logic [3:0]             bit_cnt;
  uart_cmd_pkg::divisor_t baud_cnt;
  uart_cmd_pkg::divisor_t div_q;
  uart_cmd_pkg::byte_t    shift;
  logic                   par_bit;
  logic                   mid_bit;
  logic                   bit_end;

  assign fall    = rx_s3 && !rx_s2;
  assign mid_bit = rx_busy && (baud_cnt == (div_q >> 1));
  assign bit_end = (baud_cnt == div_q - 1'b1);

  // two-flop synchronizer plus one stage for edge detect
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_s1 <= 1'b1;
      rx_s2 <= 1'b1;
      rx_s3 <= 1'b1;
    end else begin
      rx_s1 <= rx;
      rx_s2 <= rx_s1;
      rx_s3 <= rx_s2;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_busy  <= 1'b0;
      rx_vld   <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      rx_vld <= 1'b0;
      if (!rx_busy) begin
        if (rx_en && fall) begin
          rx_busy  <= 1'b1;
          baud_cnt <= '0;
          bit_cnt  <= '0;
        end
      end else if (mid_bit && bit_cnt == '0 && rx_s2) begin
        // glitch, start bit gone by mid-bit
        rx_busy <= 1'b0;
      end else begin
        if (mid_bit && bit_cnt == LAST_BIT) begin
          rx_vld <= 1'b1;
        end
        if (bit_end) begin
          baud_cnt <= '0;
          if (bit_cnt == LAST_BIT) begin
            rx_busy <= 1'b0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else begin
          baud_cnt <= baud_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rx_busy && rx_en && fall) begin
      div_q <= divisor;
    end
    if (mid_bit && bit_cnt != '0 && bit_cnt < PARITY_BIT) begin
      shift <= {rx_s2, shift[7:1]};
    end
    if (mid_bit && bit_cnt == PARITY_BIT) begin
      par_bit <= rx_s2;
    end
    // odd parity over data and parity bit must come out 1
    if (mid_bit && bit_cnt == LAST_BIT) begin
      rx_out.data       <= shift;
      rx_out.parity_err <= ~(^{par_bit, shift});
      rx_out.stop_err   <= ~rx_s2;
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_tx_frame.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_tx_frame (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire uart_cmd_pkg::divisor_t  divisor,
  input  wire                          tx_start,
  input  wire uart_cmd_pkg::byte_t     tx_byte,
  output logic                         tx,
  output logic                         tx_done
);

  localparam logic [3:0] LAST_BIT = 4'(uart_cmd_pkg::FRAME_BITS - 1);

  logic                   busy;
  logic [3:0]             bit_cnt;
  uart_cmd_pkg::divisor_t baud_cnt;
  uart_cmd_pkg::divisor_t div_q;
  // stop, parity and data still to go, LSB next
  logic [9:0]             shift;
  logic                   bit_end;
  logic                   start_ok;

  assign bit_end  = (baud_cnt == div_q - 1'b1);
  assign tx_done  = busy && bit_end && (bit_cnt == LAST_BIT);

  // a new frame may follow directly on the last stop cycle
  assign start_ok = tx_start && (!busy || tx_done);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      tx       <= 1'b1;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (start_ok) begin
      busy     <= 1'b1;
      tx       <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else if (busy) begin
      if (bit_end) begin
        baud_cnt <= '0;
        if (bit_cnt == LAST_BIT) begin
          busy <= 1'b0;
          tx   <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
          tx      <= shift[0];
        end
      end else begin
        baud_cnt <= baud_cnt + 1'b1;
      end
    end
  end

  // odd parity: ~^ gives 1 when data has an even count of ones
  always_ff @(posedge clk) begin
    if (start_ok) begin
      shift <= {1'b1, ~^tx_byte, tx_byte};
      div_q <= divisor;
    end else if (busy && bit_end) begin
      shift <= {1'b1, shift[9:1]};
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_baud_cfg.sv */
`timescale 1ns/100ps
`default_nettype none

module uart_baud_cfg #(
  parameter int CLK_HZ = 50_000_000,
  parameter int BAUD   = 115_200
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          cfg_wr,
  input  wire uart_cmd_pkg::divisor_t  cfg_divisor,
  output uart_cmd_pkg::divisor_t       divisor
);

  localparam uart_cmd_pkg::divisor_t DIV_CALC = uart_cmd_pkg::divisor_t'(CLK_HZ / BAUD);

  // reset value kept inside the legal range as well
  localparam uart_cmd_pkg::divisor_t DIV_RESET =
    (DIV_CALC < uart_cmd_pkg::DIVISOR_MIN) ? uart_cmd_pkg::DIVISOR_MIN : DIV_CALC;

  uart_cmd_pkg::divisor_t div_clamped;

  // too small a bit period cannot be sampled mid-bit
  always_comb begin
    if (cfg_divisor < uart_cmd_pkg::DIVISOR_MIN) begin
      div_clamped = uart_cmd_pkg::DIVISOR_MIN;
    end else begin
      div_clamped = cfg_divisor;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      divisor <= DIV_RESET;
    end else if (cfg_wr) begin
      divisor <= div_clamped;
    end
  end

endmodule

`default_nettype wire

/* verilog/uart_cmd_pkg.sv */
`default_nettype none

package uart_cmd_pkg;

  // one serial data byte
  typedef logic [7:0] byte_t;

  // remote register address
  typedef logic [6:0] addr_t;

  // clk cycles per serial bit
  typedef logic [15:0] divisor_t;

  // host command, rw = 1 for a read
  typedef struct packed {
    logic  rw;
    addr_t addr;
    byte_t data;
  } uart_cmd_t;

  typedef struct packed {
    byte_t data;
    logic  parity_err;
    logic  timeout;
  } uart_resp_t;

  typedef struct packed {
    byte_t data;
    logic  parity_err;
    logic  stop_err;
  } rx_byte_t;

  typedef enum logic [2:0] {
    idle,
    send_head,
    send_data,
    wait_reply,
    finish
  } master_state_t;

  // start, 8 data, parity, stop
  localparam int FRAME_BITS = 11;

  localparam divisor_t DIVISOR_MIN = 16'd4;

endpackage

`default_nettype wire
